// File: design/cpuCfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// data word width, also the instruction width.
`define CPU_DATA_WIDTH 16

// general registers, R0 reads as zero.
`define CPU_REG_COUNT 8
`define CPU_REG_BITS 3

// raw immediate field in bits 7..0.
`define CPU_IMM_BITS 8

`endif

// File: design/cpuPkg.sv
`default_nettype none

`include "cpuCfg.svh"

package cpuPkg;

    typedef logic [`CPU_DATA_WIDTH-1:0] word_t;
    typedef logic [`CPU_DATA_WIDTH-1:0] instr_t;
    typedef logic [`CPU_REG_BITS-1:0] regIdx_t;

    // opcode lives in instruction bits 15..12.
    typedef enum logic [3:0] {
        OP_ALU  = 4'h0,
        OP_ADDI = 4'h1,
        OP_LW   = 4'h2,
        OP_SW   = 4'h3,
        OP_BEQ  = 4'h4,
        OP_BLT  = 4'h5,
        OP_JMP  = 4'h6,
        OP_JAL  = 4'h7,
        OP_LUI  = 4'h8,
        OP_NOP  = 4'hf
    } opcode_t;

    typedef struct packed {
        logic src1Zero;  // srcA forced to R0.
        logic src2Rt;    // srcB from rt, else rd.
        logic linkDst;   // destination is R7.
        logic extSigned;
        logic extHigh;   // immediate goes to the high byte.
        logic regWrite;
        logic isBranch;
        logic isJump;
    } ctrl_t;

    typedef enum logic [1:0] {
        FWD_REG = 2'd0,
        FWD_EX  = 2'd1,
        FWD_MEM = 2'd2,
        FWD_WB  = 2'd3
    } fwdSrc_t;

    // result bus coming back from a later stage.
    typedef struct packed {
        logic    write;
        regIdx_t dest;
        word_t   value;
    } stageResult_t;

    typedef struct packed {
        ctrl_t   ctrl;
        opcode_t opcode;
        regIdx_t destReg;
        regIdx_t srcA;
        regIdx_t srcB;
        word_t   opA;
        word_t   opB;
        word_t   imm;
        word_t   branchTarget;
        word_t   jumpTarget;
        word_t   returnAddr;
        logic    gt;
        logic    lt;
        logic    eq;
    } idEx_t;

endpackage

`default_nettype wire

// File: design/idControl.sv
`default_nettype none
`timescale 1ns/100ps

`include "cpuCfg.svh"

module idControl (
    input  cpuPkg::instr_t  instruction,
    output cpuPkg::ctrl_t   ctrl,
    output cpuPkg::opcode_t opcode,
    output cpuPkg::regIdx_t srcA,
    output cpuPkg::regIdx_t srcB,
    output cpuPkg::regIdx_t destReg
);

    always_comb begin
        ctrl   = '0;               // unknown codes fall through as a NOP.
        opcode = cpuPkg::OP_NOP;
        case (instruction[15:12])
            cpuPkg::OP_ALU: begin
                opcode        = cpuPkg::OP_ALU;
                ctrl.src2Rt   = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            cpuPkg::OP_ADDI, cpuPkg::OP_LW: begin
                opcode         = cpuPkg::opcode_t'(instruction[15:12]);
                ctrl.extSigned = 1'b1;
                ctrl.regWrite  = 1'b1;
            end
            cpuPkg::OP_SW: begin
                opcode         = cpuPkg::OP_SW;
                ctrl.extSigned = 1'b1;  // store data comes from the rd field.
            end
            cpuPkg::OP_BEQ, cpuPkg::OP_BLT: begin
                opcode         = cpuPkg::opcode_t'(instruction[15:12]);
                ctrl.extSigned = 1'b1;
                ctrl.isBranch  = 1'b1;
            end
            cpuPkg::OP_JMP: begin
                opcode      = cpuPkg::OP_JMP;
                ctrl.isJump = 1'b1;
            end
            cpuPkg::OP_JAL: begin
                opcode        = cpuPkg::OP_JAL;
                ctrl.isJump   = 1'b1;
                ctrl.linkDst  = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            cpuPkg::OP_LUI: begin
                opcode        = cpuPkg::OP_LUI;
                ctrl.src1Zero = 1'b1;  // R0 + imm<<8.
                ctrl.extHigh  = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            default: ;
        endcase
    end

    // register index selection.
    assign srcA    = ctrl.src1Zero ? '0 : instruction[8:6];
    assign srcB    = ctrl.src2Rt ? instruction[5:3] : instruction[11:9];
    assign destReg = ctrl.linkDst ? cpuPkg::regIdx_t'(`CPU_REG_COUNT - 1) : instruction[11:9];

    always_comb begin
        assert final (!(ctrl.isBranch && ctrl.isJump))
            else $error("decode raised branch and jump together");
    end

endmodule

`default_nettype wire

// File: design/regFile.sv
`default_nettype none
`timescale 1ns/100ps

`include "cpuCfg.svh"

module regFile (
    input  wire                  clk,
    input  wire                  reset,
    input  cpuPkg::stageResult_t wbResult,
    input  cpuPkg::regIdx_t      srcA,
    input  cpuPkg::regIdx_t      srcB,
    output cpuPkg::word_t        busA,
    output cpuPkg::word_t        busB
);

    cpuPkg::word_t regs [`CPU_REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wbResult.write && (wbResult.dest != '0)) begin
            regs[wbResult.dest] <= wbResult.value;  // R0 never written.
        end
    end

    // asynchronous reads; same-cycle writes are covered by WB forwarding.
    assign busA = regs[srcA];
    assign busB = regs[srcB];

    // R0 stays zero across any history of writes.
    assert property (@(posedge clk) disable iff (reset) (srcA == '0) |-> (busA == '0))
        else $error("R0 read nonzero on port A");
    assert property (@(posedge clk) disable iff (reset) (srcB == '0) |-> (busB == '0))
        else $error("R0 read nonzero on port B");

endmodule

`default_nettype wire

// File: design/immExtender.sv
`default_nettype none
`timescale 1ns/100ps

`include "cpuCfg.svh"

module immExtender (
    input  cpuPkg::instr_t instruction,
    input  cpuPkg::ctrl_t  ctrl,
    output cpuPkg::word_t  imm
);

    localparam int FillBits = `CPU_DATA_WIDTH - `CPU_IMM_BITS;

    logic [`CPU_IMM_BITS-1:0] rawImm;

    assign rawImm = instruction[`CPU_IMM_BITS-1:0];

    always_comb begin
        if (ctrl.extHigh) begin
            imm = {rawImm, {FillBits{1'b0}}};  // LUI form.
        end else if (ctrl.extSigned) begin
            imm = {{FillBits{rawImm[`CPU_IMM_BITS-1]}}, rawImm};
        end else begin
            imm = {{FillBits{1'b0}}, rawImm};
        end
    end

endmodule

`default_nettype wire

// File: design/operandForward.sv
`default_nettype none
`timescale 1ns/100ps

module operandForward (
    input  cpuPkg::regIdx_t      srcA,
    input  cpuPkg::regIdx_t      srcB,
    input  cpuPkg::word_t        busA,
    input  cpuPkg::word_t        busB,
    input  cpuPkg::stageResult_t exResult,
    input  cpuPkg::stageResult_t memResult,
    input  cpuPkg::stageResult_t wbResult,
    output cpuPkg::word_t        opA,
    output cpuPkg::word_t        opB
);

    cpuPkg::fwdSrc_t selA;
    cpuPkg::fwdSrc_t selB;

    // youngest result wins: EX, then MEM, then WB.
    function automatic cpuPkg::fwdSrc_t pickSrc(input cpuPkg::regIdx_t src,
                                                input cpuPkg::stageResult_t ex,
                                                input cpuPkg::stageResult_t mem,
                                                input cpuPkg::stageResult_t wb);
        if (src == '0) return cpuPkg::FWD_REG;
        if (ex.write && ex.dest == src) return cpuPkg::FWD_EX;
        if (mem.write && mem.dest == src) return cpuPkg::FWD_MEM;
        if (wb.write && wb.dest == src) return cpuPkg::FWD_WB;
        return cpuPkg::FWD_REG;
    endfunction

    function automatic cpuPkg::word_t muxSrc(input cpuPkg::fwdSrc_t sel,
                                             input cpuPkg::word_t bus,
                                             input cpuPkg::word_t exVal,
                                             input cpuPkg::word_t memVal,
                                             input cpuPkg::word_t wbVal);
        case (sel)
            cpuPkg::FWD_EX:  return exVal;
            cpuPkg::FWD_MEM: return memVal;
            cpuPkg::FWD_WB:  return wbVal;
            default:         return bus;
        endcase
    endfunction

    assign selA = pickSrc(srcA, exResult, memResult, wbResult);
    assign selB = pickSrc(srcB, exResult, memResult, wbResult);

    assign opA = muxSrc(selA, busA, exResult.value, memResult.value, wbResult.value);
    assign opB = muxSrc(selB, busB, exResult.value, memResult.value, wbResult.value);

    always_comb begin
        assert final ((srcA != '0 || selA == cpuPkg::FWD_REG) &&
                      (srcB != '0 || selB == cpuPkg::FWD_REG))
            else $error("R0 operand was forwarded from a later stage");
    end

endmodule

`default_nettype wire

// File: design/branchResolve.sv
`default_nettype none
`timescale 1ns/100ps

module branchResolve (
    input  cpuPkg::word_t  opA,
    input  cpuPkg::word_t  opB,
    input  cpuPkg::word_t  imm,
    input  cpuPkg::word_t  npc,
    input  cpuPkg::instr_t instruction,
    output cpuPkg::word_t  branchTarget,
    output cpuPkg::word_t  jumpTarget,
    output cpuPkg::word_t  returnAddr,
    output logic           gt,
    output logic           lt,
    output logic           eq
);

    // signed compare of the forwarded operands.
    assign gt = $signed(opA) > $signed(opB);
    assign lt = $signed(opA) < $signed(opB);
    assign eq = (opA == opB);

    assign branchTarget = npc + imm;                        // pc-relative.
    assign jumpTarget   = {npc[15:12], instruction[11:0]};  // region jump.

    // JAL links the fall-through address into R7.
    assign returnAddr = npc;

endmodule

`default_nettype wire

// File: design/idExLatch.sv
`default_nettype none
`timescale 1ns/100ps

module idExLatch (
    input  wire           clk,
    input  wire           reset,
    input  wire           stall,
    input  wire           flush,
    input  cpuPkg::idEx_t next,
    output cpuPkg::idEx_t idEx
);

    cpuPkg::idEx_t bubble;

    // bubble is an all-zero bundle tagged as NOP.
    always_comb begin
        bubble        = '0;
        bubble.opcode = cpuPkg::OP_NOP;
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            idEx <= bubble;  // flush beats stall.
        end else if (!stall) begin
            idEx <= next;
        end
    end

    assert property (@(posedge clk) disable iff (reset) flush |=> !idEx.ctrl.regWrite)
        else $error("flushed slot still writes a register");

endmodule

`default_nettype wire

// File: design/decodeStage.sv
`default_nettype none
`timescale 1ns/100ps

module decodeStage (
    input  wire                  clk,
    input  wire                  reset,
    input  cpuPkg::instr_t       instruction,
    input  cpuPkg::word_t        npc,
    input  wire                  stall,
    input  wire                  flush,
    input  cpuPkg::stageResult_t exResult,
    input  cpuPkg::stageResult_t memResult,
    input  cpuPkg::stageResult_t wbResult,
    output cpuPkg::idEx_t        idEx
);

    cpuPkg::ctrl_t   ctrl;
    cpuPkg::opcode_t opcode;
    cpuPkg::regIdx_t srcA;
    cpuPkg::regIdx_t srcB;
    cpuPkg::regIdx_t destReg;
    cpuPkg::word_t   busA;
    cpuPkg::word_t   busB;
    cpuPkg::word_t   imm;
    cpuPkg::word_t   opA;
    cpuPkg::word_t   opB;
    cpuPkg::word_t   branchTarget;
    cpuPkg::word_t   jumpTarget;
    cpuPkg::word_t   returnAddr;
    logic            gt;
    logic            lt;
    logic            eq;
    cpuPkg::idEx_t   nextIdEx;

    idControl i_idControl (
        .instruction(instruction),
        .ctrl       (ctrl),
        .opcode     (opcode),
        .srcA       (srcA),
        .srcB       (srcB),
        .destReg    (destReg)
    );

    regFile i_regFile (
        .clk     (clk),
        .reset   (reset),
        .wbResult(wbResult),  // write-back drives the write port.
        .srcA    (srcA),
        .srcB    (srcB),
        .busA    (busA),
        .busB    (busB)
    );

    immExtender i_immExtender (
        .instruction(instruction),
        .ctrl       (ctrl),
        .imm        (imm)
    );

    operandForward i_operandForward (
        .srcA     (srcA),
        .srcB     (srcB),
        .busA     (busA),
        .busB     (busB),
        .exResult (exResult),
        .memResult(memResult),
        .wbResult (wbResult),
        .opA      (opA),
        .opB      (opB)
    );

    branchResolve i_branchResolve (
        .opA         (opA),
        .opB         (opB),
        .imm         (imm),
        .npc         (npc),
        .instruction (instruction),
        .branchTarget(branchTarget),
        .jumpTarget  (jumpTarget),
        .returnAddr  (returnAddr),
        .gt          (gt),
        .lt          (lt),
        .eq          (eq)
    );

    // bundle for the ID/EX register.
    assign nextIdEx = '{ctrl: ctrl, opcode: opcode, destReg: destReg,
                        srcA: srcA, srcB: srcB, opA: opA, opB: opB, imm: imm,
                        branchTarget: branchTarget, jumpTarget: jumpTarget,
                        returnAddr: returnAddr, gt: gt, lt: lt, eq: eq};

    idExLatch i_idExLatch (
        .clk  (clk),
        .reset(reset),
        .stall(stall),
        .flush(flush),
        .next (nextIdEx),
        .idEx (idEx)
    );

endmodule

`default_nettype wire

// File: bench/decodeStageTb.sv
`default_nettype none
`timescale 1ns/100ps

`include "cpuCfg.svh"

module decodeStageTb;

    // one table row holds the stimulus and the expected decode.
    typedef struct packed {
        cpuPkg::instr_t       instr;
        cpuPkg::word_t        npc;
        logic                 stall;
        logic                 flush;
        cpuPkg::stageResult_t ex;
        cpuPkg::stageResult_t mem;
        cpuPkg::stageResult_t wb;
        cpuPkg::ctrl_t        ctrl;
        cpuPkg::opcode_t      opcode;
        cpuPkg::regIdx_t      destReg;
        cpuPkg::regIdx_t      srcA;
        cpuPkg::regIdx_t      srcB;
        cpuPkg::word_t        imm;
        cpuPkg::word_t        opA;     // filled from the register model.
        cpuPkg::word_t        opB;
    } row_t;

    // ctrl bits from msb down are src1Zero src2Rt linkDst extSigned extHigh regWrite isBranch isJump.
    localparam cpuPkg::ctrl_t CtrlNone   = 8'h00;
    localparam cpuPkg::ctrl_t CtrlAlu    = 8'h44;
    localparam cpuPkg::ctrl_t CtrlImm    = 8'h14;
    localparam cpuPkg::ctrl_t CtrlStore  = 8'h10;
    localparam cpuPkg::ctrl_t CtrlBranch = 8'h12;
    localparam cpuPkg::ctrl_t CtrlJump   = 8'h01;
    localparam cpuPkg::ctrl_t CtrlLink   = 8'h25;
    localparam cpuPkg::ctrl_t CtrlLui    = 8'h8c;

    logic                 clk = 1'b0;
    logic                 reset;
    cpuPkg::instr_t       instruction;
    cpuPkg::word_t        npc;
    logic                 stall;
    logic                 flush;
    cpuPkg::stageResult_t exResult;
    cpuPkg::stageResult_t memResult;
    cpuPkg::stageResult_t wbResult;
    cpuPkg::idEx_t        idEx;

    row_t                 rows[$];
    cpuPkg::word_t        model[`CPU_REG_COUNT];  // reference register file.
    cpuPkg::stageResult_t nextEx;
    cpuPkg::stageResult_t nextMem;
    cpuPkg::stageResult_t nextWb;
    logic                 nextStall;
    logic                 nextFlush;
    logic [15:0]          lfsr = 16'd41;
    int                   cycleCount = 0;

    decodeStage i_dut (
        .clk        (clk),
        .reset      (reset),
        .instruction(instruction),
        .npc        (npc),
        .stall      (stall),
        .flush      (flush),
        .exResult   (exResult),
        .memResult  (memResult),
        .wbResult   (wbResult),
        .idEx       (idEx)
    );

    always #4 clk = ~clk;

    // watchdog on the whole run.
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > 500) begin
            failRun("simulation ran past its limit of 500 cycles.");
        end
    end

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "stopped at %0t.", $time);
    endtask

    task automatic checkField(input string name, input cpuPkg::word_t got,
                              input cpuPkg::word_t want);
        assert (got == want)
            else failRun($sformatf("error: idEx.%s is %h, expected %h", name, got, want));
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic drawWord(output cpuPkg::word_t w);
        w = '0;
        for (int i = 0; i < 16; i++) begin
            w    = {w[14:0], lfsr[15]};  // one step per bit.
            lfsr = lfsrNext(lfsr);
        end
    endtask

    task automatic randomResult(input cpuPkg::regIdx_t dest, output cpuPkg::stageResult_t r);
        cpuPkg::word_t v;
        drawWord(v);
        r = '{write: 1'b1, dest: dest, value: v};
    endtask

    // youngest matching result wins and R0 is never forwarded.
    function automatic cpuPkg::word_t expectOperand(input cpuPkg::regIdx_t src);
        if (src == '0) return '0;
        if (nextEx.write && nextEx.dest == src) return nextEx.value;
        if (nextMem.write && nextMem.dest == src) return nextMem.value;
        if (nextWb.write && nextWb.dest == src) return nextWb.value;
        return model[src];
    endfunction

    task automatic addRow(input cpuPkg::instr_t instr, input cpuPkg::word_t pc,
                          input cpuPkg::ctrl_t c, input cpuPkg::opcode_t op,
                          input cpuPkg::regIdx_t d, input cpuPkg::regIdx_t a,
                          input cpuPkg::regIdx_t b, input cpuPkg::word_t imm);
        row_t r;
        r = '{instr: instr, npc: pc, stall: nextStall, flush: nextFlush, ex: nextEx,
              mem: nextMem, wb: nextWb, ctrl: c, opcode: op, destReg: d, srcA: a,
              srcB: b, imm: imm, opA: expectOperand(a), opB: expectOperand(b)};
        rows.push_back(r);
        if (nextWb.write && nextWb.dest != '0) begin
            model[nextWb.dest] = nextWb.value;  // visible from the next row on.
        end
        nextEx    = '0;
        nextMem   = '0;
        nextWb    = '0;
        nextStall = 1'b0;
        nextFlush = 1'b0;
    endtask

    task automatic buildTable();
        // R0 write is dropped and every register reads zero after reset.
        nextWb = '{write: 1'b1, dest: 3'd0, value: 16'hbeef};
        addRow(16'h0200, 16'h0010, CtrlAlu, cpuPkg::OP_ALU, 3'd1, 3'd0, 3'd0, 16'h0000);
        addRow(16'h0428, 16'h0012, CtrlAlu, cpuPkg::OP_ALU, 3'd2, 3'd0, 3'd5, 16'h0028);
        addRow(16'h0050, 16'h0014, CtrlAlu, cpuPkg::OP_ALU, 3'd0, 3'd1, 3'd2, 16'h0050);
        addRow(16'h00e0, 16'h0016, CtrlAlu, cpuPkg::OP_ALU, 3'd0, 3'd3, 3'd4, 16'h00e0);
        addRow(16'h01f0, 16'h0018, CtrlAlu, cpuPkg::OP_ALU, 3'd0, 3'd7, 3'd6, 16'h00f0);

        // write-back followed by reads of R3 in the cycle it is written.
        randomResult(3'd1, nextWb);
        addRow(16'hf000, 16'h0020, CtrlNone, cpuPkg::OP_NOP, 3'd0, 3'd0, 3'd0, 16'h0000);
        randomResult(3'd2, nextWb);
        addRow(16'hf000, 16'h0022, CtrlNone, cpuPkg::OP_NOP, 3'd0, 3'd0, 3'd0, 16'h0000);
        randomResult(3'd3, nextWb);
        addRow(16'h0858, 16'h0024, CtrlAlu, cpuPkg::OP_ALU, 3'd4, 3'd1, 3'd3, 16'h0058);
        addRow(16'h0a98, 16'h0026, CtrlAlu, cpuPkg::OP_ALU, 3'd5, 3'd2, 3'd3, 16'h0098);

        // forwarding priority on R6.
        randomResult(3'd6, nextWb);
        addRow(16'hf000, 16'h0030, CtrlNone, cpuPkg::OP_NOP, 3'd0, 3'd0, 3'd0, 16'h0000);
        randomResult(3'd6, nextEx);
        randomResult(3'd6, nextMem);
        randomResult(3'd6, nextWb);
        addRow(16'h0380, 16'h0032, CtrlAlu, cpuPkg::OP_ALU, 3'd1, 3'd6, 3'd0, 16'h0080);
        randomResult(3'd6, nextMem);
        randomResult(3'd6, nextWb);
        addRow(16'h0380, 16'h0034, CtrlAlu, cpuPkg::OP_ALU, 3'd1, 3'd6, 3'd0, 16'h0080);
        randomResult(3'd6, nextWb);
        addRow(16'h0380, 16'h0036, CtrlAlu, cpuPkg::OP_ALU, 3'd1, 3'd6, 3'd0, 16'h0080);
        randomResult(3'd0, nextEx);
        randomResult(3'd0, nextMem);
        randomResult(3'd0, nextWb);
        addRow(16'h0200, 16'h0038, CtrlAlu, cpuPkg::OP_ALU, 3'd1, 3'd0, 3'd0, 16'h0000);
        addRow(16'h0380, 16'h003a, CtrlAlu, cpuPkg::OP_ALU, 3'd1, 3'd6, 3'd0, 16'h0080);

        // immediates and targets.
        addRow(16'h14f6, 16'h0040, CtrlImm, cpuPkg::OP_ADDI, 3'd2, 3'd3, 3'd2, 16'hfff6);
        addRow(16'h86a5, 16'h0042, CtrlLui, cpuPkg::OP_LUI, 3'd3, 3'd0, 3'd3, 16'ha500);
        addRow(16'h4810, 16'h2000, CtrlBranch, cpuPkg::OP_BEQ, 3'd4, 3'd0, 3'd4, 16'h0010);
        addRow(16'h5a80, 16'h2000, CtrlBranch, cpuPkg::OP_BLT, 3'd5, 3'd2, 3'd5, 16'hff80);
        addRow(16'h3c7f, 16'h0044, CtrlStore, cpuPkg::OP_SW, 3'd6, 3'd1, 3'd6, 16'h007f);
        addRow(16'h6abc, 16'h7123, CtrlJump, cpuPkg::OP_JMP, 3'd5, 3'd2, 3'd5, 16'h00bc);
        addRow(16'h7345, 16'hc010, CtrlLink, cpuPkg::OP_JAL, 3'd7, 3'd5, 3'd1, 16'h0045);
        addRow(16'hc123, 16'h0048, CtrlNone, cpuPkg::OP_NOP, 3'd0, 3'd4, 3'd0, 16'h0023);

        // compare flags on random pairs with the last pair equal.
        for (int k = 0; k < 6; k++) begin
            randomResult(3'd1, nextEx);
            randomResult(3'd2, nextMem);
            if (k == 5) begin
                nextMem.value = nextEx.value;
            end
            addRow(16'h0650, 16'h0050, CtrlAlu, cpuPkg::OP_ALU, 3'd3, 3'd1, 3'd2, 16'h0050);
        end

        // stall holds and flush beats stall.
        addRow(16'h0858, 16'h0060, CtrlAlu, cpuPkg::OP_ALU, 3'd4, 3'd1, 3'd3, 16'h0058);
        nextStall = 1'b1;
        addRow(16'h14f6, 16'h0062, CtrlImm, cpuPkg::OP_ADDI, 3'd2, 3'd3, 3'd2, 16'hfff6);
        nextStall = 1'b1;
        addRow(16'h14f6, 16'h0062, CtrlImm, cpuPkg::OP_ADDI, 3'd2, 3'd3, 3'd2, 16'hfff6);
        addRow(16'h14f6, 16'h0062, CtrlImm, cpuPkg::OP_ADDI, 3'd2, 3'd3, 3'd2, 16'hfff6);
        nextStall = 1'b1;
        nextFlush = 1'b1;
        addRow(16'h0650, 16'h0064, CtrlAlu, cpuPkg::OP_ALU, 3'd3, 3'd1, 3'd2, 16'h0050);
        nextStall = 1'b1;
        addRow(16'h0650, 16'h0064, CtrlAlu, cpuPkg::OP_ALU, 3'd3, 3'd1, 3'd2, 16'h0050);
        addRow(16'h0650, 16'h0064, CtrlAlu, cpuPkg::OP_ALU, 3'd3, 3'd1, 3'd2, 16'h0050);
    endtask

    task automatic applyRow(input row_t r);
        instruction = r.instr;
        npc         = r.npc;
        stall       = r.stall;
        flush       = r.flush;
        exResult    = r.ex;
        memResult   = r.mem;
        wbResult    = r.wb;
    endtask

    task automatic checkOutput(input row_t e, input logic bubble);
        cpuPkg::word_t wantJump;
        logic          wantGt;
        logic          wantLt;
        wantJump = {e.npc[15:12], e.instr[11:0]};
        wantGt   = $signed(e.opA) > $signed(e.opB);
        wantLt   = $signed(e.opA) < $signed(e.opB);
        if (bubble) begin
            checkField("ctrl", 16'(idEx.ctrl), 16'h0000);
            checkField("opcode", 16'(idEx.opcode), 16'(cpuPkg::OP_NOP));
        end else begin
            checkField("ctrl", 16'(idEx.ctrl), 16'(e.ctrl));
            checkField("opcode", 16'(idEx.opcode), 16'(e.opcode));
            checkField("destReg", 16'(idEx.destReg), 16'(e.destReg));
            checkField("srcA", 16'(idEx.srcA), 16'(e.srcA));
            checkField("srcB", 16'(idEx.srcB), 16'(e.srcB));
            checkField("opA", idEx.opA, e.opA);
            checkField("opB", idEx.opB, e.opB);
            checkField("imm", idEx.imm, e.imm);
            checkField("branchTarget", idEx.branchTarget, e.npc + e.imm);
            checkField("jumpTarget", idEx.jumpTarget, wantJump);
            checkField("returnAddr", idEx.returnAddr, e.npc);
            checkField("gt", 16'(idEx.gt), 16'(wantGt));
            checkField("lt", 16'(idEx.lt), 16'(wantLt));
            checkField("eq", 16'(idEx.eq), 16'(e.opA == e.opB));
        end
    endtask

    task automatic waitFalling(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
        end
    endtask

    initial begin
        row_t held;
        logic heldBubble;
        reset       = 1'b1;
        instruction = 16'hf000;
        npc         = '0;
        stall       = 1'b0;
        flush       = 1'b0;
        exResult    = '0;
        memResult   = '0;
        wbResult    = '0;
        nextEx      = '0;
        nextMem     = '0;
        nextWb      = '0;
        nextStall   = 1'b0;
        nextFlush   = 1'b0;
        foreach (model[k]) begin
            model[k] = '0;
        end
        buildTable();

        waitFalling(8);
        reset = 1'b0;
        held       = '0;
        heldBubble = 1'b1;
        checkOutput(held, heldBubble);  // bubble straight out of reset.

        foreach (rows[i]) begin
            applyRow(rows[i]);
            if (rows[i].flush) begin
                heldBubble = 1'b1;
            end else if (!rows[i].stall) begin
                held       = rows[i];
                heldBubble = 1'b0;
            end
            waitFalling(1);  // one cycle of latency.
            checkOutput(held, heldBubble);
        end

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+design
design/cpuPkg.sv
design/idControl.sv
design/regFile.sv
design/immExtender.sv
design/operandForward.sv
design/branchResolve.sv
design/idExLatch.sv
design/decodeStage.sv
bench/decodeStageTb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
TOP       ?= decodeStageTb
FILELIST  ?= build.f
OBJDIR    ?= obj_dir
PASSMSG   := Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP) 2>&1)"; echo "$$out"; echo "$$out" | grep -q "^$(PASSMSG)$$"

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
